/* Bender.yml */
package:
  name: radio_block

sources:
  - radio_regs_pkg.sv
  - radio_types_pkg.sv
  - timekeeper.sv
  - settings_bus_mux.sv
  - radio_rx_framer.sv
  - radio_tx_deframer.sv
  - radio_core.sv
  - radio_block.sv
  - target: test
    files:
      - tb_radio_block.sv

/* radio_block.sv */
// Multi-channel radio block
// One shared timekeeper fed through the settings mux, plus one radio
// channel per entry of the per-channel port arrays
`default_nettype none

module radio_block #(
  parameter int NUM_CHANNELS = 2
) (
  input  logic                      i_ce_clk,
  input  logic                      i_rst,
  input  logic                      i_pps,
  input  radio_types_pkg::set_bus_t i_set       [NUM_CHANNELS],
  input  radio_types_pkg::sample_t  i_rx_sample [NUM_CHANNELS],
  input  logic [NUM_CHANNELS-1:0]   i_rx_stb,
  output radio_types_pkg::rx_axis_t o_rx        [NUM_CHANNELS],
  output logic [NUM_CHANNELS-1:0]   o_rx_valid,
  input  logic [NUM_CHANNELS-1:0]   i_rx_ready,
  input  radio_types_pkg::tx_axis_t i_tx        [NUM_CHANNELS],
  input  logic [NUM_CHANNELS-1:0]   i_tx_valid,
  output logic [NUM_CHANNELS-1:0]   o_tx_ready,
  input  logic [NUM_CHANNELS-1:0]   i_tx_stb,
  output radio_types_pkg::sample_t  o_tx_sample [NUM_CHANNELS],
  output logic [NUM_CHANNELS-1:0]   o_rb_stb,
  output radio_types_pkg::rb_data_t o_rb_data   [NUM_CHANNELS],
  output radio_types_pkg::set_bus_t o_ext_set   [NUM_CHANNELS]
);
  import radio_types_pkg::*;

  set_bus_t   set_shared;
  vita_time_t vita_time;
  vita_time_t vita_time_lastpps;

  ////////////////////
  // Shared time
  ////////////////////
  settings_bus_mux #(
    .NUM_CHANNELS(NUM_CHANNELS)
  ) settings_bus_mux_inst (
    .i_ce_clk(i_ce_clk),
    .i_rst   (i_rst),
    .i_set   (i_set),
    .o_set   (set_shared)
  );

  // Time runs off channel 0's sample strobe
  timekeeper timekeeper_inst (
    .i_ce_clk           (i_ce_clk),
    .i_rst              (i_rst),
    .i_pps              (i_pps),
    .i_strobe           (i_rx_stb[0]),
    .i_set              (set_shared),
    .o_vita_time        (vita_time),
    .o_vita_time_lastpps(vita_time_lastpps)
  );

  ////////////////////
  // Channels
  ////////////////////
  for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : gen_chan
    radio_core #(
      .RADIO_NUM(ch)
    ) radio_core_inst (
      .i_ce_clk           (i_ce_clk),
      .i_rst              (i_rst),
      .i_set              (i_set[ch]),
      .i_vita_time        (vita_time),
      .i_vita_time_lastpps(vita_time_lastpps),
      .i_rx_sample        (i_rx_sample[ch]),
      .i_rx_stb           (i_rx_stb[ch]),
      .o_rx               (o_rx[ch]),
      .o_rx_valid         (o_rx_valid[ch]),
      .i_rx_ready         (i_rx_ready[ch]),
      .i_tx               (i_tx[ch]),
      .i_tx_valid         (i_tx_valid[ch]),
      .o_tx_ready         (o_tx_ready[ch]),
      .i_tx_stb           (i_tx_stb[ch]),
      .o_tx_sample        (o_tx_sample[ch]),
      .o_rb_stb           (o_rb_stb[ch]),
      .o_rb_data          (o_rb_data[ch]),
      .o_ext_set          (o_ext_set[ch])
    );
  end

endmodule

`default_nettype wire

/* radio_core.sv */
// Radio channel
// Channel settings registers, readback mux and external settings decode,
// around the RX framer and TX deframer
`default_nettype none

module radio_core #(
  parameter int RADIO_NUM = 0
) (
  input  logic                        i_ce_clk,
  input  logic                        i_rst,
  input  radio_types_pkg::set_bus_t   i_set,
  input  radio_types_pkg::vita_time_t i_vita_time,
  input  radio_types_pkg::vita_time_t i_vita_time_lastpps,
  input  radio_types_pkg::sample_t    i_rx_sample,
  input  logic                        i_rx_stb,
  output radio_types_pkg::rx_axis_t   o_rx,
  output logic                        o_rx_valid,
  input  logic                        i_rx_ready,
  input  radio_types_pkg::tx_axis_t   i_tx,
  input  logic                        i_tx_valid,
  output logic                        o_tx_ready,
  input  logic                        i_tx_stb,
  output radio_types_pkg::sample_t    o_tx_sample,
  output logic                        o_rb_stb,
  output radio_types_pkg::rb_data_t   o_rb_data,
  output radio_types_pkg::set_bus_t   o_ext_set
);
  import radio_types_pkg::*;
  import radio_regs_pkg::*;

  localparam set_addr_t DEFAULT_PKT_LEN = 8'd255;

  logic      rx_enable;
  logic      tx_enable;
  set_addr_t rx_pkt_len;
  set_data_t overflow_count;
  set_data_t underrun_count;
  logic      wr_rb;
  rb_data_t  rb_sel;

  ////////////////////
  // Channel registers
  ////////////////////
  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      rx_enable  <= 1'b0;
      tx_enable  <= 1'b0;
      rx_pkt_len <= DEFAULT_PKT_LEN;
    end else if (i_set.stb) begin
      case (i_set.addr)
        SR_RX_CTRL:    rx_enable  <= i_set.data[CTRL_ENABLE_BIT];
        SR_RX_PKT_LEN: rx_pkt_len <= i_set.data[$bits(set_addr_t)-1:0];
        SR_TX_CTRL:    tx_enable  <= i_set.data[CTRL_ENABLE_BIT];
        default:       ;
      endcase
    end
  end

  ////////////////////
  // Readback
  ////////////////////
  assign wr_rb = i_set.stb && (i_set.addr == SR_RB_ADDR);

  // Selected straight from the write data, so values are taken at the write edge
  always_comb begin
    case (i_set.data[7:0])
      RB_VITA_TIME:    rb_sel = i_vita_time;
      RB_VITA_LASTPPS: rb_sel = i_vita_time_lastpps;
      RB_RX_OVERFLOW:  rb_sel = {32'd0, overflow_count};
      RB_TX_UNDERRUN:  rb_sel = {32'd0, underrun_count};
      RB_COMPAT:       rb_sel = {COMPAT_VERSION, 40'd0, 8'(RADIO_NUM)};
      default:         rb_sel = '0;
    endcase
  end

  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      o_rb_stb <= 1'b0;
    end else begin
      o_rb_stb <= wr_rb;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (wr_rb) begin
      o_rb_data <= rb_sel;
    end
  end

  // External settings pass through, strobe only for the upper address range
  assign o_ext_set = '{stb:  i_set.stb && (i_set.addr >= SR_EXTERNAL_BASE),
                       addr: i_set.addr,
                       data: i_set.data};

  radio_rx_framer radio_rx_framer_inst (
    .i_ce_clk        (i_ce_clk),
    .i_rst           (i_rst),
    .i_enable        (rx_enable),
    .i_pkt_len       (rx_pkt_len),
    .i_vita_time     (i_vita_time),
    .i_rx_sample     (i_rx_sample),
    .i_rx_stb        (i_rx_stb),
    .o_rx            (o_rx),
    .o_rx_valid      (o_rx_valid),
    .i_rx_ready      (i_rx_ready),
    .o_overflow_count(overflow_count)
  );

  radio_tx_deframer radio_tx_deframer_inst (
    .i_ce_clk        (i_ce_clk),
    .i_rst           (i_rst),
    .i_enable        (tx_enable),
    .i_tx            (i_tx),
    .i_tx_valid      (i_tx_valid),
    .o_tx_ready      (o_tx_ready),
    .i_tx_stb        (i_tx_stb),
    .o_tx_sample     (o_tx_sample),
    .o_underrun_count(underrun_count)
  );

endmodule

`default_nettype wire

/* radio_regs_pkg.sv */
// Radio register map
// Settings addresses, control bit positions and readback codes shared by
// the timekeeper and the radio channels
`default_nettype none

package radio_regs_pkg;

  ////////////////////
  // Settings addresses
  ////////////////////
  localparam logic [7:0] SR_TIME_HI       = 8'd8;
  localparam logic [7:0] SR_TIME_LO       = 8'd9;
  localparam logic [7:0] SR_TIME_CTRL     = 8'd10;
  localparam logic [7:0] SR_RX_CTRL       = 8'd16;
  localparam logic [7:0] SR_RX_PKT_LEN    = 8'd17;
  localparam logic [7:0] SR_TX_CTRL       = 8'd24;
  localparam logic [7:0] SR_RB_ADDR       = 8'd32;
  // Everything from here up goes out on the external bus
  localparam logic [7:0] SR_EXTERNAL_BASE = 8'd128;

  // Control word bits
  localparam int TIME_CTRL_NOW_BIT = 0;
  localparam int TIME_CTRL_PPS_BIT = 1;
  localparam int CTRL_ENABLE_BIT   = 0;

  ////////////////////
  // Readback codes
  ////////////////////
  localparam logic [7:0] RB_VITA_TIME    = 8'd0;
  localparam logic [7:0] RB_VITA_LASTPPS = 8'd1;
  localparam logic [7:0] RB_RX_OVERFLOW  = 8'd2;
  localparam logic [7:0] RB_TX_UNDERRUN  = 8'd3;
  localparam logic [7:0] RB_COMPAT       = 8'd4;

  // Version reported in the top bits of RB_COMPAT
  localparam logic [15:0] COMPAT_VERSION = 16'h0102;

endpackage

`default_nettype wire

/* radio_rx_framer.sv */
// RX framer
// Packs strobed front-end samples into length-limited stream packets,
// stamped with the time of the first sample, and counts dropped samples
`default_nettype none

module radio_rx_framer (
  input  logic                        i_ce_clk,
  input  logic                        i_rst,
  input  logic                        i_enable,
  input  radio_types_pkg::set_addr_t  i_pkt_len,
  input  radio_types_pkg::vita_time_t i_vita_time,
  input  radio_types_pkg::sample_t    i_rx_sample,
  input  logic                        i_rx_stb,
  output radio_types_pkg::rx_axis_t   o_rx,
  output logic                        o_rx_valid,
  input  logic                        i_rx_ready,
  output radio_types_pkg::set_data_t  o_overflow_count
);
  import radio_types_pkg::*;

  set_addr_t len_eff;
  set_addr_t sample_cnt;
  logic      out_free;
  logic      accept_stb;
  logic      drop_stb;
  logic      pkt_end;

  // Length 0 behaves as single-sample packets
  assign len_eff = (i_pkt_len == '0) ? set_addr_t'(1) : i_pkt_len;

  // Output register can take a sample if empty or draining this cycle
  assign out_free   = !o_rx_valid || i_rx_ready;
  assign accept_stb = i_enable && i_rx_stb && out_free;
  assign drop_stb   = i_enable && i_rx_stb && !out_free;

  // >= so a shortened length still closes the packet
  assign pkt_end = (sample_cnt >= (len_eff - set_addr_t'(1)));

  ////////////////////
  // Control
  ////////////////////
  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      o_rx_valid       <= 1'b0;
      sample_cnt       <= '0;
      o_overflow_count <= '0;
    end else begin
      if (accept_stb) begin
        o_rx_valid <= 1'b1;
      end else if (i_rx_ready) begin
        o_rx_valid <= 1'b0;
      end

      // Disable or a drop abandons the packet in progress
      if (!i_enable || drop_stb) begin
        sample_cnt <= '0;
      end else if (accept_stb) begin
        sample_cnt <= pkt_end ? '0 : sample_cnt + 1'b1;
      end

      if (drop_stb) begin
        o_overflow_count <= o_overflow_count + 1'b1;
      end
    end
  end

  ////////////////////
  // Output beat
  ////////////////////
  always_ff @(posedge i_ce_clk) begin
    if (accept_stb) begin
      o_rx.tdata <= i_rx_sample;
      o_rx.tlast <= pkt_end;
      // Timestamp stays put for the rest of the packet
      if (sample_cnt == '0) begin
        o_rx.tuser <= i_vita_time;
      end
    end
  end

endmodule

`default_nettype wire

/* radio_tx_deframer.sv */
// TX deframer
// Hands one stream sample to the front end on each TX strobe, sends zero
// when the stream has nothing, and counts those underruns
`default_nettype none

module radio_tx_deframer (
  input  logic                       i_ce_clk,
  input  logic                       i_rst,
  input  logic                       i_enable,
  input  radio_types_pkg::tx_axis_t  i_tx,
  input  logic                       i_tx_valid,
  output logic                       o_tx_ready,
  input  logic                       i_tx_stb,
  output radio_types_pkg::sample_t   o_tx_sample,
  output radio_types_pkg::set_data_t o_underrun_count
);
  import radio_types_pkg::*;

  logic take_sample;
  logic underrun;

  // Pull a beat only when the front end asks for one
  assign o_tx_ready  = i_tx_stb && i_enable;
  assign take_sample = o_tx_ready && i_tx_valid;
  assign underrun    = o_tx_ready && !i_tx_valid;

  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      o_tx_sample      <= '0;
      o_underrun_count <= '0;
    end else begin
      if (i_tx_stb) begin
        // Zero fill when disabled or starved
        o_tx_sample <= take_sample ? i_tx.tdata : sample_t'(0);
      end
      if (underrun) begin
        o_underrun_count <= o_underrun_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* radio_types_pkg.sv */
// Radio data types
// Time, sample and settings widths plus the bundles used on the settings
// bus and on the RX and TX sample streams
`default_nettype none

package radio_types_pkg;

  // Plain widths
  typedef logic [63:0] vita_time_t;
  typedef logic [31:0] sample_t;
  typedef logic [7:0]  set_addr_t;
  typedef logic [31:0] set_data_t;
  typedef logic [63:0] rb_data_t;

  // Strobed settings write, one cycle per write
  typedef struct packed {
    logic      stb;
    set_addr_t addr;
    set_data_t data;
  } set_bus_t;

  // RX stream beat
  // tuser carries the time of the first sample in the packet
  typedef struct packed {
    sample_t    tdata;
    vita_time_t tuser;
    logic       tlast;
  } rx_axis_t;

  // TX stream beat
  typedef struct packed {
    sample_t tdata;
    logic    tlast;
  } tx_axis_t;

endpackage

`default_nettype wire

/* settings_bus_mux.sv */
// Settings bus multiplexer
// Merges the per-channel settings writes onto one bus, lowest channel first,
// holding one pending write per channel
`default_nettype none

module settings_bus_mux #(
  parameter int NUM_CHANNELS = 2
) (
  input  logic                      i_ce_clk,
  input  logic                      i_rst,
  input  radio_types_pkg::set_bus_t i_set [NUM_CHANNELS],
  output radio_types_pkg::set_bus_t o_set
);
  import radio_types_pkg::*;

  logic [NUM_CHANNELS-1:0] pend_valid;
  set_addr_t               pend_addr [NUM_CHANNELS];
  set_data_t               pend_data [NUM_CHANNELS];
  logic [NUM_CHANNELS-1:0] eff_valid;
  set_addr_t               eff_addr  [NUM_CHANNELS];
  set_data_t               eff_data  [NUM_CHANNELS];
  logic [NUM_CHANNELS-1:0] grant;
  set_addr_t               sel_addr;
  set_data_t               sel_data;
  logic                    out_stb;
  set_addr_t               out_addr;
  set_data_t               out_data;

  // A fresh write replaces whatever the channel still has pending
  always_comb begin
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      eff_valid[ch] = i_set[ch].stb | pend_valid[ch];
      eff_addr[ch]  = i_set[ch].stb ? i_set[ch].addr : pend_addr[ch];
      eff_data[ch]  = i_set[ch].stb ? i_set[ch].data : pend_data[ch];
    end
  end

  // Fixed priority, one-hot grant
  always_comb begin
    grant    = '0;
    sel_addr = '0;
    sel_data = '0;
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      if (eff_valid[ch] && (grant == '0)) begin
        grant[ch] = 1'b1;
        sel_addr  = eff_addr[ch];
        sel_data  = eff_data[ch];
      end
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      pend_valid <= '0;
      out_stb    <= 1'b0;
    end else begin
      pend_valid <= eff_valid & ~grant;
      out_stb    <= |eff_valid;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      pend_addr[ch] <= eff_addr[ch];
      pend_data[ch] <= eff_data[ch];
    end
    out_addr <= sel_addr;
    out_data <= sel_data;
  end

  assign o_set = '{stb: out_stb, addr: out_addr, data: out_data};

endmodule

`default_nettype wire

/* tb_radio_block.sv */
// Radio block testbench
// Directed tests of time load and count, PPS capture, RX framing and
// overflow, TX underrun and the external settings bus
`default_nettype none

module tb_radio_block;
  import radio_types_pkg::*;
  import radio_regs_pkg::*;

  localparam int NUM_CH          = 2;
  localparam int PKT_LEN         = 4;
  localparam int TIMEOUT_CYCLES  = 4000;
  localparam int BEAT_WAIT_LIMIT = 20;

  logic                ce_clk = 1'b0;
  logic                rst;
  logic                pps;
  set_bus_t            set_in    [NUM_CH];
  sample_t             rx_sample [NUM_CH];
  logic [NUM_CH-1:0]   rx_stb;
  rx_axis_t            rx_out    [NUM_CH];
  logic [NUM_CH-1:0]   rx_valid;
  logic [NUM_CH-1:0]   rx_ready;
  tx_axis_t            tx_in     [NUM_CH];
  logic [NUM_CH-1:0]   tx_valid;
  logic [NUM_CH-1:0]   tx_ready;
  logic [NUM_CH-1:0]   tx_stb;
  sample_t             tx_sample [NUM_CH];
  logic [NUM_CH-1:0]   rb_stb;
  rb_data_t            rb_data   [NUM_CH];
  set_bus_t            ext_set   [NUM_CH];

  logic [31:0] rng_state   = 32'h8c4;
  vita_time_t  model_time  = '0;
  int          cycle_count = 0;

  radio_block #(
    .NUM_CHANNELS(NUM_CH)
  ) radio_block_inst (
    .i_ce_clk   (ce_clk),
    .i_rst      (rst),
    .i_pps      (pps),
    .i_set      (set_in),
    .i_rx_sample(rx_sample),
    .i_rx_stb   (rx_stb),
    .o_rx       (rx_out),
    .o_rx_valid (rx_valid),
    .i_rx_ready (rx_ready),
    .i_tx       (tx_in),
    .i_tx_valid (tx_valid),
    .o_tx_ready (tx_ready),
    .i_tx_stb   (tx_stb),
    .o_tx_sample(tx_sample),
    .o_rb_stb   (rb_stb),
    .o_rb_data  (rb_data),
    .o_ext_set  (ext_set)
  );

  always #4 ce_clk = ~ce_clk;

  always @(posedge ce_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  ////////////////////
  // Checks
  ////////////////////
  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_time(input string name, input vita_time_t got, input vita_time_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_rb(input string name, input rb_data_t got, input rb_data_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_set(input string name, input set_bus_t got, input set_bus_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  ////////////////////
  // Stimulus helpers
  ////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic sample_t next_sample();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic idle(input int n);
    repeat (n) @(negedge ce_clk);
  endtask

  task automatic write_setting(input int ch, input set_addr_t addr, input set_data_t data);
    @(negedge ce_clk);
    set_in[ch] = '{stb: 1'b1, addr: addr, data: data};
    @(negedge ce_clk);
    set_in[ch].stb = 1'b0;
  endtask

  // Strobe lands one cycle after the write and lasts exactly one cycle
  task automatic read_back(input int ch, input logic [7:0] code, output rb_data_t value);
    @(negedge ce_clk);
    set_in[ch] = '{stb: 1'b1, addr: SR_RB_ADDR, data: set_data_t'(code)};
    @(negedge ce_clk);
    set_in[ch].stb = 1'b0;
    check_bit("o_rb_stb", rb_stb[ch], 1'b1);
    value = rb_data[ch];
    @(negedge ce_clk);
    check_bit("o_rb_stb", rb_stb[ch], 1'b0);
  endtask

  // Channel 0 strobes also advance the shared time
  task automatic strobe_rx(input int ch, input sample_t sample, output vita_time_t stamp);
    @(negedge ce_clk);
    rx_sample[ch] = sample;
    rx_stb[ch]    = 1'b1;
    stamp         = model_time;
    @(negedge ce_clk);
    rx_stb[ch] = 1'b0;
    if (ch == 0) begin
      model_time = model_time + 1;
    end
  endtask

  task automatic count_strobes(input int n);
    vita_time_t unused;
    repeat (n) strobe_rx(0, '0, unused);
  endtask

  task automatic expect_rx_beat(input int ch, input sample_t exp_data,
                                input vita_time_t exp_time, input logic exp_last);
    int waited;
    waited = 0;
    while (rx_valid[ch] !== 1'b1) begin
      if (waited >= BEAT_WAIT_LIMIT) begin
        $display("No RX beat on channel %0d within %0d cycles", ch, BEAT_WAIT_LIMIT);
        abort_run();
      end
      @(negedge ce_clk);
      waited++;
    end
    check_sample("o_rx.tdata", rx_out[ch].tdata, exp_data);
    check_time("o_rx.tuser", rx_out[ch].tuser, exp_time);
    check_bit("o_rx.tlast", rx_out[ch].tlast, exp_last);
    @(negedge ce_clk);
  endtask

  // Each packet's tuser is the stamp of its first sample
  task automatic rx_stream(input int ch, input int nsamp);
    sample_t    s;
    vita_time_t t;
    vita_time_t first_t;
    for (int i = 0; i < nsamp; i++) begin
      s = next_sample();
      strobe_rx(ch, s, t);
      if ((i % PKT_LEN) == 0) begin
        first_t = t;
      end
      expect_rx_beat(ch, s, first_t, (i % PKT_LEN) == (PKT_LEN - 1));
    end
  endtask

  task automatic ext_write_check(input int ch, input set_addr_t addr, input set_data_t data,
                                 input logic exp_stb);
    @(negedge ce_clk);
    set_in[ch] = '{stb: 1'b1, addr: addr, data: data};
    @(posedge ce_clk);
    for (int c = 0; c < NUM_CH; c++) begin
      check_bit("o_ext_set.stb", ext_set[c].stb, (c == ch) && exp_stb);
    end
    if (exp_stb) begin
      check_set("o_ext_set", ext_set[ch], '{stb: 1'b1, addr: addr, data: data});
    end
    @(negedge ce_clk);
    set_in[ch].stb = 1'b0;
  endtask

  ////////////////////
  // Directed tests
  ////////////////////
  task automatic test_reset_state();
    rb_data_t rb;
    for (int c = 0; c < NUM_CH; c++) begin
      check_bit("o_rx_valid", rx_valid[c], 1'b0);
      check_bit("o_tx_ready", tx_ready[c], 1'b0);
      check_bit("o_rb_stb", rb_stb[c], 1'b0);
      check_bit("o_ext_set.stb", ext_set[c].stb, 1'b0);
    end
    read_back(0, RB_VITA_TIME, rb);
    check_time("RB_VITA_TIME", rb, '0);
    read_back(1, RB_VITA_LASTPPS, rb);
    check_time("RB_VITA_LASTPPS", rb, '0);
  endtask

  task automatic test_time_load();
    vita_time_t load;
    rb_data_t   rb;
    // Low word close to wrapping so counting carries into the high word
    load = 64'h0000_0001_ffff_fff0;
    write_setting(1, SR_TIME_HI, load[63:32]);
    idle(4);
    write_setting(1, SR_TIME_LO, load[31:0]);
    idle(4);
    write_setting(1, SR_TIME_CTRL, 32'h1);
    idle(4);
    model_time = load;
    count_strobes(20);
    read_back(0, RB_VITA_TIME, rb);
    check_time("RB_VITA_TIME", rb, model_time);
  endtask

  task automatic test_pps_load();
    vita_time_t load;
    vita_time_t exp_lastpps;
    rb_data_t   rb;
    load = 64'h0000_00a0_0000_0100;
    write_setting(1, SR_TIME_HI, load[63:32]);
    idle(4);
    write_setting(1, SR_TIME_LO, load[31:0]);
    idle(4);
    write_setting(1, SR_TIME_CTRL, 32'h2);
    idle(4);
    // Armed with no PPS yet so time keeps counting
    count_strobes(3);
    read_back(0, RB_VITA_TIME, rb);
    check_time("RB_VITA_TIME", rb, model_time);
    @(negedge ce_clk);
    pps = 1'b1;
    @(negedge ce_clk);
    pps = 1'b0;
    exp_lastpps = model_time;
    model_time  = load;
    count_strobes(5);
    read_back(0, RB_VITA_TIME, rb);
    check_time("RB_VITA_TIME", rb, model_time);
    read_back(1, RB_VITA_LASTPPS, rb);
    check_time("RB_VITA_LASTPPS", rb, exp_lastpps);
  endtask

  task automatic test_rx_packets();
    rb_data_t rb;
    for (int c = 0; c < NUM_CH; c++) begin
      write_setting(c, SR_RX_PKT_LEN, PKT_LEN);
      write_setting(c, SR_RX_CTRL, 32'h1);
      rx_ready[c] = 1'b1;
      rx_stream(c, 2 * PKT_LEN);
      read_back(c, RB_COMPAT, rb);
      check_rb("RB_COMPAT", rb, {COMPAT_VERSION, 40'd0, 8'(c)});
    end
  endtask

  task automatic test_rx_overflow();
    sample_t    s0;
    vita_time_t t0;
    vita_time_t unused;
    rb_data_t   rb;
    rx_ready[0] = 1'b0;
    s0 = next_sample();
    strobe_rx(0, s0, t0);
    strobe_rx(0, next_sample(), unused);
    strobe_rx(0, next_sample(), unused);
    // First beat held while the other two are dropped
    check_bit("o_rx_valid", rx_valid[0], 1'b1);
    check_sample("o_rx.tdata", rx_out[0].tdata, s0);
    check_time("o_rx.tuser", rx_out[0].tuser, t0);
    read_back(0, RB_RX_OVERFLOW, rb);
    check_rb("RB_RX_OVERFLOW", rb, 64'd2);
    rx_ready[0] = 1'b1;
    expect_rx_beat(0, s0, t0, 1'b0);
    rx_stream(0, PKT_LEN);
  endtask

  task automatic test_tx_underrun();
    sample_t  tx_q [$];
    sample_t  expected;
    rb_data_t rb;
    write_setting(1, SR_TX_CTRL, 32'h1);
    repeat (3) tx_q.push_back(next_sample());
    for (int i = 0; i < 5; i++) begin
      @(negedge ce_clk);
      if (i < tx_q.size()) begin
        tx_in[1]    = '{tdata: tx_q[i], tlast: (i == tx_q.size() - 1)};
        tx_valid[1] = 1'b1;
        expected    = tx_q[i];
      end else begin
        tx_valid[1] = 1'b0;
        expected    = '0;
      end
      tx_stb[1] = 1'b1;
      @(posedge ce_clk);
      check_bit("o_tx_ready", tx_ready[1], 1'b1);
      @(negedge ce_clk);
      tx_stb[1]   = 1'b0;
      tx_valid[1] = 1'b0;
      check_sample("o_tx_sample", tx_sample[1], expected);
    end
    read_back(1, RB_TX_UNDERRUN, rb);
    check_rb("RB_TX_UNDERRUN", rb, 64'd2);
  endtask

  task automatic test_external_bus();
    ext_write_check(1, 8'd200, 32'h1234_5678, 1'b1);
    ext_write_check(1, SR_RX_CTRL, 32'h0, 1'b0);
  endtask

  initial begin
    rst      = 1'b1;
    pps      = 1'b0;
    rx_stb   = '0;
    rx_ready = '0;
    tx_valid = '0;
    tx_stb   = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      set_in[c]    = '0;
      rx_sample[c] = '0;
      tx_in[c]     = '0;
    end
    repeat (4) @(negedge ce_clk);
    rst = 1'b0;

    test_reset_state();
    test_time_load();
    test_pps_load();
    test_rx_packets();
    test_rx_overflow();
    test_tx_underrun();
    test_external_bus();
    idle(4);

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* timekeeper.sv */
// Shared VITA timekeeper
// Counts front-end strobes, loads a new time now or at the next PPS edge
// and captures the time at every PPS edge
`default_nettype none

module timekeeper (
  input  logic                        i_ce_clk,
  input  logic                        i_rst,
  input  logic                        i_pps,
  input  logic                        i_strobe,
  input  radio_types_pkg::set_bus_t   i_set,
  output radio_types_pkg::vita_time_t o_vita_time,
  output radio_types_pkg::vita_time_t o_vita_time_lastpps
);
  import radio_types_pkg::*;
  import radio_regs_pkg::*;

  set_data_t time_hi;
  set_data_t time_lo;
  logic      armed;
  logic      pps_d;
  logic      pps_rise;
  logic      wr_ctrl;
  logic      load_now;
  logic      load_pps;

  assign pps_rise = i_pps & ~pps_d;
  assign wr_ctrl  = i_set.stb && (i_set.addr == SR_TIME_CTRL);
  assign load_now = wr_ctrl && i_set.data[TIME_CTRL_NOW_BIT];
  assign load_pps = armed && pps_rise;

  // Load value, written ahead of the control word
  always_ff @(posedge i_ce_clk) begin
    if (i_set.stb && (i_set.addr == SR_TIME_HI)) begin
      time_hi <= i_set.data;
    end
    if (i_set.stb && (i_set.addr == SR_TIME_LO)) begin
      time_lo <= i_set.data;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      o_vita_time         <= '0;
      o_vita_time_lastpps <= '0;
      armed               <= 1'b0;
      pps_d               <= 1'b0;
    end else begin
      pps_d <= i_pps;
      // Load wins over counting
      if (load_now || load_pps) begin
        o_vita_time <= {time_hi, time_lo};
      end else if (i_strobe) begin
        o_vita_time <= o_vita_time + 1'b1;
      end
      if (pps_rise) begin
        o_vita_time_lastpps <= o_vita_time;
      end
      // Arming write takes precedence over a same-cycle disarm
      if (load_pps) begin
        armed <= 1'b0;
      end
      if (wr_ctrl && i_set.data[TIME_CTRL_PPS_BIT]) begin
        armed <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
radio_regs_pkg.sv
radio_types_pkg.sv
timekeeper.sv
settings_bus_mux.sv
radio_rx_framer.sv
radio_tx_deframer.sv
radio_core.sv
radio_block.sv
tb_radio_block.sv
